// ==== design/rvfi_pkg.sv ====
// RVFI tracer package
// Widths, the load/store size encoding and the record structs shared by the
// retirement tracer stages and its testbench

package rvfi_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int ORDER_W    = 64;
  localparam int MASK_W     = 4;
  localparam int INSN_C_W   = 16;

  // Access size as reported by the decoder
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10,
    LSU_NONE = 2'b11
  } lsu_size_e;

  // One instruction leaving decode
  typedef struct packed {
    logic                  compressed;
    logic [INSN_C_W-1:0]   insn_c;
    logic [XLEN-1:0]       insn;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [XLEN-1:0]       rs1_rdata;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs2_rdata;
    logic [XLEN-1:0]       pc_rdata;
    logic [XLEN-1:0]       pc_wdata;
    logic                  lsu_req;
    logic                  lsu_we;
    lsu_size_e             lsu_size;
    logic                  illegal;
  } rvfi_decode_t;

  // Memory access seen in execute
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } rvfi_lsu_t;

  // Register file write from writeback
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       wdata;
  } rvfi_rd_t;

  // Full retirement record
  typedef struct packed {
    logic                  valid;
    logic [ORDER_W-1:0]    order;
    logic [XLEN-1:0]       insn;
    logic                  trap;
    logic                  intr;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_rdata;
    logic [XLEN-1:0]       rs2_rdata;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_wdata;
    logic [XLEN-1:0]       pc_rdata;
    logic [XLEN-1:0]       pc_wdata;
    logic [XLEN-1:0]       mem_addr;
    logic [MASK_W-1:0]     mem_rmask;
    logic [MASK_W-1:0]     mem_wmask;
    logic [XLEN-1:0]       mem_rdata;
    logic [XLEN-1:0]       mem_wdata;
    // Set while a load or store is in flight
    logic                  mem;
  } rvfi_instr_t;

endpackage

// ==== design/rvfi_decode_capture.sv ====
// RVFI decode capture
// Builds a trace record from each decoded instruction, numbers it in
// retirement order and holds it until execute takes it

`timescale 1ns/1ps

module rvfi_decode_capture (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   id_valid_i,
  input  rvfi_pkg::rvfi_decode_t id_i,
  input  logic                   ex_ready_i,
  output logic                   slot_valid_o,
  output rvfi_pkg::rvfi_instr_t  slot_o
);

  logic [rvfi_pkg::ORDER_W-1:0] order_q;
  logic [rvfi_pkg::ORDER_W-1:0] order_next;
  logic [rvfi_pkg::MASK_W-1:0]  size_mask;
  logic                         slot_valid_q;
  rvfi_pkg::rvfi_instr_t        rec_d;
  rvfi_pkg::rvfi_instr_t        slot_q;

  assign order_next = order_q + 1'b1;

  // Byte mask from the access size
  always_comb begin
    unique case (id_i.lsu_size)
      rvfi_pkg::LSU_BYTE: size_mask = 4'b0001;
      rvfi_pkg::LSU_HALF: size_mask = 4'b0011;
      rvfi_pkg::LSU_WORD: size_mask = 4'b1111;
      default:            size_mask = 4'b0000;
    endcase
  end

  always_comb begin
    rec_d           = '0;
    rec_d.valid     = 1'b1;
    rec_d.order     = order_next;
    rec_d.trap      = id_i.illegal;
    rec_d.insn      = id_i.compressed ?
                      {{(rvfi_pkg::XLEN-rvfi_pkg::INSN_C_W){1'b0}}, id_i.insn_c} : id_i.insn;
    rec_d.rs1_addr  = id_i.rs1_addr;
    rec_d.rs2_addr  = id_i.rs2_addr;
    // x0 always reads as zero
    rec_d.rs1_rdata = (id_i.rs1_addr == '0) ? '0 : id_i.rs1_rdata;
    rec_d.rs2_rdata = (id_i.rs2_addr == '0) ? '0 : id_i.rs2_rdata;
    rec_d.pc_rdata  = id_i.pc_rdata;
    rec_d.pc_wdata  = id_i.pc_wdata;
    // Illegal instructions never reach memory
    rec_d.mem       = id_i.lsu_req && !id_i.illegal;
    if (rec_d.mem) begin
      rec_d.mem_rmask = id_i.lsu_we ? '0 : size_mask;
      rec_d.mem_wmask = id_i.lsu_we ? size_mask : '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid_q <= 1'b0;
      order_q      <= '0;
    end else begin
      slot_valid_q <= id_valid_i || (slot_valid_q && !ex_ready_i);
      if (id_valid_i) begin
        order_q <= order_next;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (id_valid_i) begin
      slot_q <= rec_d;
    end
  end

  assign slot_valid_o = slot_valid_q;
  assign slot_o       = slot_q;

endmodule

// ==== design/rvfi_execute_stage.sv ====
// RVFI execute stage
// Holds the instruction in execute and adds the memory address and the
// store data rotated onto its byte lane

`timescale 1ns/1ps

module rvfi_execute_stage (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  in_valid_i,
  input  rvfi_pkg::rvfi_instr_t in_i,
  input  logic                  ex_ready_i,
  input  rvfi_pkg::rvfi_lsu_t   lsu_i,
  input  logic                  lsu_rvalid_i,
  output logic                  slot_valid_o,
  output rvfi_pkg::rvfi_instr_t slot_o
);

  logic                          take;
  logic                          leave;
  logic                          slot_valid_q;
  logic [2*rvfi_pkg::XLEN-1:0]   wdata_ror;
  rvfi_pkg::rvfi_instr_t         slot_q;

  assign take  = ex_ready_i && in_valid_i;
  // Memory instructions stay until their response arrives
  assign leave = slot_valid_q && (!slot_q.mem || lsu_rvalid_i);

  // Rotate right by the byte offset
  assign wdata_ror = {lsu_i.wdata, lsu_i.wdata} >> {lsu_i.addr[1:0], 3'b000};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid_q <= 1'b0;
    end else begin
      slot_valid_q <= take || (slot_valid_q && !leave);
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      slot_q <= in_i;
      if (in_i.mem) begin
        slot_q.mem_addr <= lsu_i.addr;
        // Loads keep zero store data
        if (in_i.mem_wmask != '0) begin
          slot_q.mem_wdata <= wdata_ror[rvfi_pkg::XLEN-1:0];
        end
      end
    end
  end

  assign slot_valid_o = slot_valid_q;
  assign slot_o       = slot_q;

endmodule

// ==== design/rvfi_writeback_stage.sv ====
// RVFI writeback stage
// Retires the instruction leaving execute. Adds load data, the register
// write and the trap target, then presents the record for one cycle

`timescale 1ns/1ps

module rvfi_writeback_stage (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        in_valid_i,
  input  rvfi_pkg::rvfi_instr_t       in_i,
  input  logic                        lsu_rvalid_i,
  input  logic [rvfi_pkg::XLEN-1:0]   lsu_rdata_i,
  input  rvfi_pkg::rvfi_rd_t          rd_i,
  input  logic [rvfi_pkg::XLEN-1:0]   trap_target_i,
  output rvfi_pkg::rvfi_instr_t       rec_o
);

  logic                              retire;
  logic                              valid_q;
  logic [rvfi_pkg::REG_ADDR_W-1:0]   rd_addr;
  rvfi_pkg::rvfi_instr_t             rec_d;
  rvfi_pkg::rvfi_instr_t             out_q;

  // Instruction leaves execute in this cycle
  assign retire = in_valid_i && (!in_i.mem || lsu_rvalid_i);

  assign rd_addr = rd_i.we ? rd_i.addr : '0;

  always_comb begin
    rec_d          = in_i;
    rec_d.valid    = 1'b1;
    rec_d.intr     = 1'b0;
    rec_d.mem      = 1'b0;
    rec_d.rd_addr  = rd_addr;
    rec_d.rd_wdata = (rd_addr == '0) ? '0 : rd_i.wdata;
    if (in_i.mem && (in_i.mem_rmask != '0)) begin
      rec_d.mem_rdata = lsu_rdata_i;
    end
    if (in_i.trap) begin
      rec_d.pc_wdata = trap_target_i;
    end
    // Half-word aligned next pc
    rec_d.pc_wdata[0] = 1'b0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= retire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire) begin
      out_q <= rec_d;
    end
  end

  always_comb begin
    rec_o       = out_q;
    rec_o.valid = valid_q;
  end

endmodule

// ==== design/rvfi_intr_detect.sv ====
// RVFI interrupt detect
// Flags a retirement as the first instruction of a trap handler when its pc
// does not follow on from the previous retirement

`timescale 1ns/1ps

module rvfi_intr_detect (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  rvfi_pkg::rvfi_instr_t rec_i,
  output logic                  intr_o
);

  logic                          last_valid_q;
  logic [rvfi_pkg::ORDER_W-1:0]  last_order_q;
  logic [rvfi_pkg::XLEN-1:0]     last_pc_wdata_q;
  logic [rvfi_pkg::ORDER_W-1:0]  next_order;

  assign next_order = last_order_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_valid_q <= 1'b0;
    end else if (rec_i.valid) begin
      last_valid_q <= 1'b1;
    end
  end

  // Order and next pc of the last retirement
  always_ff @(posedge clk_i) begin
    if (rec_i.valid) begin
      last_order_q    <= rec_i.order;
      last_pc_wdata_q <= rec_i.pc_wdata;
    end
  end

  assign intr_o = rec_i.valid &&
                  last_valid_q &&
                  (rec_i.order == next_order) &&
                  (rec_i.pc_rdata != last_pc_wdata_q);

endmodule

// ==== design/rvfi_tracer.sv ====
// RVFI retirement tracer
// Follows each instruction of a three-stage core through decode, execute
// and writeback and emits one RVFI record when it retires

`timescale 1ns/1ps

module rvfi_tracer (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        id_valid_i,
  input  rvfi_pkg::rvfi_decode_t      id_i,
  input  logic                        ex_ready_i,
  input  rvfi_pkg::rvfi_lsu_t         lsu_i,
  input  logic                        lsu_rvalid_i,
  input  logic [rvfi_pkg::XLEN-1:0]   lsu_rdata_i,
  input  rvfi_pkg::rvfi_rd_t          rd_i,
  input  logic [rvfi_pkg::XLEN-1:0]   trap_target_i,
  output rvfi_pkg::rvfi_instr_t       rvfi_o
);

  logic                  id_slot_valid;
  rvfi_pkg::rvfi_instr_t id_slot;
  logic                  ex_slot_valid;
  rvfi_pkg::rvfi_instr_t ex_slot;
  rvfi_pkg::rvfi_instr_t wb_rec;
  logic                  intr;

  rvfi_decode_capture rvfi_decode_capture_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .id_valid_i   (id_valid_i),
    .id_i         (id_i),
    .ex_ready_i   (ex_ready_i),
    .slot_valid_o (id_slot_valid),
    .slot_o       (id_slot)
  );

  rvfi_execute_stage rvfi_execute_stage_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (id_slot_valid),
    .in_i         (id_slot),
    .ex_ready_i   (ex_ready_i),
    .lsu_i        (lsu_i),
    .lsu_rvalid_i (lsu_rvalid_i),
    .slot_valid_o (ex_slot_valid),
    .slot_o       (ex_slot)
  );

  rvfi_writeback_stage rvfi_writeback_stage_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .in_valid_i    (ex_slot_valid),
    .in_i          (ex_slot),
    .lsu_rvalid_i  (lsu_rvalid_i),
    .lsu_rdata_i   (lsu_rdata_i),
    .rd_i          (rd_i),
    .trap_target_i (trap_target_i),
    .rec_o         (wb_rec)
  );

  rvfi_intr_detect rvfi_intr_detect_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .rec_i  (wb_rec),
    .intr_o (intr)
  );

  // Writeback record with the interrupt flag filled in
  always_comb begin
    rvfi_o      = wb_rec;
    rvfi_o.intr = intr;
  end

endmodule

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and reset
// Makes a 100 ns clock and holds the active-low reset for 10 cycles

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int RESET_CYCLES = 10;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// ==== verification/tb_rvfi_tracer.sv ====
// RVFI tracer testbench
// Reads instructions and expected retirement fields from the test file,
// drives the core side under random stalls and checks every record

`timescale 1ns/1ps

module tb_rvfi_tracer;

  localparam int NUM_TESTS      = 14;
  localparam int WORDS_PER_TEST = 32;
  localparam int RESET_CYCLES   = 10;
  localparam int MAX_CYCLES     = NUM_TESTS * 40 + RESET_CYCLES;

  logic                        clk;
  logic                        rst_n;
  logic                        id_valid;
  rvfi_pkg::rvfi_decode_t      id;
  logic                        ex_ready;
  rvfi_pkg::rvfi_lsu_t         lsu;
  logic                        lsu_rvalid;
  logic [rvfi_pkg::XLEN-1:0]   lsu_rdata;
  rvfi_pkg::rvfi_rd_t          rd;
  logic [rvfi_pkg::XLEN-1:0]   trap_target;
  rvfi_pkg::rvfi_instr_t       rvfi;

  logic [31:0] test_mem [NUM_TESTS*WORDS_PER_TEST];
  integer      seed;
  int          error_count   = 0;
  int          retired_count = 0;
  int          cycle_count   = 0;

  tb_clock_gen tb_clock_gen_inst (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  rvfi_tracer rvfi_tracer_inst (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .id_valid_i    (id_valid),
    .id_i          (id),
    .ex_ready_i    (ex_ready),
    .lsu_i         (lsu),
    .lsu_rvalid_i  (lsu_rvalid),
    .lsu_rdata_i   (lsu_rdata),
    .rd_i          (rd),
    .trap_target_i (trap_target),
    .rvfi_o        (rvfi)
  );

  // Words 0 to 12 of a test hold the decode fields, 13 to 19 the core
  // response and 20 to 31 the expected record
  function automatic rvfi_pkg::rvfi_decode_t decode_of(input int idx);
    rvfi_pkg::rvfi_decode_t d;
    int                     b;
    b            = idx * WORDS_PER_TEST;
    d.compressed = test_mem[b][0];
    d.insn_c     = test_mem[b+1][15:0];
    d.insn       = test_mem[b+2];
    d.rs1_addr   = test_mem[b+3][4:0];
    d.rs1_rdata  = test_mem[b+4];
    d.rs2_addr   = test_mem[b+5][4:0];
    d.rs2_rdata  = test_mem[b+6];
    d.pc_rdata   = test_mem[b+7];
    d.pc_wdata   = test_mem[b+8];
    d.lsu_req    = test_mem[b+9][0];
    d.lsu_we     = test_mem[b+10][0];
    d.lsu_size   = rvfi_pkg::lsu_size_e'(test_mem[b+11][1:0]);
    d.illegal    = test_mem[b+12][0];
    return d;
  endfunction

  // A trapped instruction never waits for memory
  function automatic logic is_mem(input int idx);
    int b;
    b = idx * WORDS_PER_TEST;
    return test_mem[b+9][0] && !test_mem[b+12][0];
  endfunction

  function automatic rvfi_pkg::rvfi_lsu_t lsu_of(input int idx);
    rvfi_pkg::rvfi_lsu_t l;
    l.addr  = test_mem[idx*WORDS_PER_TEST+13];
    l.wdata = test_mem[idx*WORDS_PER_TEST+14];
    return l;
  endfunction

  function automatic rvfi_pkg::rvfi_rd_t rd_of(input int idx);
    rvfi_pkg::rvfi_rd_t r;
    r.we    = test_mem[idx*WORDS_PER_TEST+16][0];
    r.addr  = test_mem[idx*WORDS_PER_TEST+17][4:0];
    r.wdata = test_mem[idx*WORDS_PER_TEST+18];
    return r;
  endfunction

  function automatic rvfi_pkg::rvfi_instr_t expected_record(input int idx);
    rvfi_pkg::rvfi_instr_t e;
    int                    b;
    b           = idx * WORDS_PER_TEST;
    e           = '0;
    e.order     = 64'(idx) + 64'd1;
    e.insn      = test_mem[b+20];
    e.trap      = test_mem[b+30][0];
    e.rs1_addr  = test_mem[b+3][4:0];
    e.rs2_addr  = test_mem[b+5][4:0];
    e.rs1_rdata = test_mem[b+21];
    e.rs2_rdata = test_mem[b+22];
    e.rd_addr   = test_mem[b+23][4:0];
    e.rd_wdata  = test_mem[b+24];
    e.pc_rdata  = test_mem[b+7];
    e.pc_wdata  = test_mem[b+25];
    e.mem_rmask = test_mem[b+26][3:0];
    e.mem_wmask = test_mem[b+27][3:0];
    e.mem_rdata = test_mem[b+28];
    e.mem_wdata = test_mem[b+29];
    // Address only shows for accesses that reach memory
    if ((e.mem_rmask | e.mem_wmask) != '0) begin
      e.mem_addr = test_mem[b+13];
    end
    return e;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      error_count++;
      $display("FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_record(input rvfi_pkg::rvfi_instr_t exp,
                                input rvfi_pkg::rvfi_instr_t act);
    check_value("order", exp.order, act.order);
    check_value("insn", 64'(exp.insn), 64'(act.insn));
    check_value("trap", 64'(exp.trap), 64'(act.trap));
    check_value("rs1_addr", 64'(exp.rs1_addr), 64'(act.rs1_addr));
    check_value("rs2_addr", 64'(exp.rs2_addr), 64'(act.rs2_addr));
    check_value("rs1_rdata", 64'(exp.rs1_rdata), 64'(act.rs1_rdata));
    check_value("rs2_rdata", 64'(exp.rs2_rdata), 64'(act.rs2_rdata));
    check_value("rd_addr", 64'(exp.rd_addr), 64'(act.rd_addr));
    check_value("rd_wdata", 64'(exp.rd_wdata), 64'(act.rd_wdata));
    check_value("pc_rdata", 64'(exp.pc_rdata), 64'(act.pc_rdata));
    check_value("pc_wdata", 64'(exp.pc_wdata), 64'(act.pc_wdata));
    check_value("mem_addr", 64'(exp.mem_addr), 64'(act.mem_addr));
    check_value("mem_rmask", 64'(exp.mem_rmask), 64'(act.mem_rmask));
    check_value("mem_wmask", 64'(exp.mem_wmask), 64'(act.mem_wmask));
    check_value("mem_rdata", 64'(exp.mem_rdata), 64'(act.mem_rdata));
    check_value("mem_wdata", 64'(exp.mem_wdata), 64'(act.mem_wdata));
    check_value("mem", 64'(exp.mem), 64'(act.mem));
  endtask

  task automatic compare_intr(input logic exp, input logic act);
    if (exp !== act) begin
      error_count++;
      $display("FAILED intr expected %h actual %h", exp, act);
    end
  endtask

  // Retirement monitor sampling mid-cycle
  always @(negedge clk) begin
    if (rst_n && rvfi.valid === 1'b1) begin
      if (retired_count < NUM_TESTS) begin
        compare_record(expected_record(retired_count), rvfi);
        compare_intr(test_mem[retired_count*WORDS_PER_TEST+31][0], rvfi.intr);
      end else begin
        error_count++;
        $display("Extra retirement after the last test, order %0d", rvfi.order);
      end
      retired_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, %0d of %0d instructions retired",
               cycle_count, retired_count, NUM_TESTS);
      $display("errors: %0d", error_count + 1);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    int   next_idx;
    int   id_idx;
    int   ex_idx;
    int   lsu_delay;
    logic id_full;
    logic ex_full;
    logic ex_mem;
    logic issue;
    logic take;
    logic leave;
    logic issue_q;
    logic take_q;
    logic leave_q;
    seed        = 32'hb04b3d67;
    id_valid    = 1'b0;
    id          = '0;
    ex_ready    = 1'b0;
    lsu         = '0;
    lsu_rvalid  = 1'b0;
    lsu_rdata   = '0;
    rd          = '0;
    trap_target = '0;
    next_idx    = 0;
    id_idx      = 0;
    ex_idx      = 0;
    lsu_delay   = 0;
    id_full     = 1'b0;
    ex_full     = 1'b0;
    ex_mem      = 1'b0;
    issue_q     = 1'b0;
    take_q      = 1'b0;
    leave_q     = 1'b0;
    $readmemh("verification/rvfi_tracer_tests.txt", test_mem);
    @(posedge rst_n);

    while (next_idx < NUM_TESTS || id_full || ex_full || issue_q || take_q) begin
      @(posedge clk);
      // Slot contents after this edge as the core tracks them
      if (leave_q) begin
        ex_full = 1'b0;
      end
      if (take_q) begin
        ex_full   = 1'b1;
        ex_idx    = id_idx;
        ex_mem    = is_mem(id_idx);
        lsu_delay = $unsigned($random(seed)) % 5;
      end
      if (issue_q) begin
        id_full = 1'b1;
        id_idx  = next_idx;
        next_idx++;
      end else if (take_q) begin
        id_full = 1'b0;
      end

      leave = ex_full && (!ex_mem || lsu_delay == 0);
      take  = id_full && (!ex_full || leave) && (($random(seed) & 3) != 0);
      issue = (next_idx < NUM_TESTS) && (!id_full || take) && (($random(seed) & 3) != 0);

      id_valid    <= issue;
      id          <= issue ? decode_of(next_idx) : '0;
      ex_ready    <= take;
      lsu         <= take ? lsu_of(id_idx) : '0;
      lsu_rvalid  <= ex_full && ex_mem && (lsu_delay == 0);
      lsu_rdata   <= ex_full ? test_mem[ex_idx*WORDS_PER_TEST+15] : '0;
      rd          <= ex_full ? rd_of(ex_idx) : '0;
      trap_target <= ex_full ? test_mem[ex_idx*WORDS_PER_TEST+19] : '0;

      if (ex_full && ex_mem && lsu_delay != 0) begin
        lsu_delay--;
      end
      issue_q = issue;
      take_q  = take;
      leave_q = leave;
    end

    wait (retired_count >= NUM_TESTS);
    // Leave room for a duplicate record to show up
    repeat (5) @(posedge clk);
    if (retired_count != NUM_TESTS) begin
      error_count++;
      $display("Retired %0d instructions but %0d were issued", retired_count, NUM_TESTS);
    end
    $display("errors: %0d, retired: %0d", error_count, retired_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== verification/rvfi_tracer_tests.txt ====
// Three lines per test. 1: compressed insn_c insn rs1 rs1_data rs2 rs2_data pc pc_next req we size
// 2: illegal lsu_addr lsu_wdata load_data rd_we rd_addr rd_data trap_target
// 3 expected: insn rs1_data rs2_data rd rd_data pc_wdata rmask wmask rdata wdata trap intr
0 0000 00500093 00 deadbeef 05 00000007 80000000 80000004 0 0 3
0 00000000 00000000 00000000 1 01 00000005 00000000
00500093 00000000 00000007 01 00000005 80000004 0 0 00000000 00000000 0 0
1 0505 ffffffff 0a 00000010 00 00000000 80000004 80000006 0 0 3
0 00000000 00000000 00000000 1 0a 00000011 00000000
00000505 00000010 00000000 0a 00000011 80000006 0 0 00000000 00000000 0 0
0 0000 00000033 00 00000000 00 00000000 80000006 8000000a 0 0 3
0 00000000 00000000 00000000 1 00 00001234 00000000
00000033 00000000 00000000 00 00000000 8000000a 0 0 00000000 00000000 0 0
0 0000 00000013 00 00000000 00 00000000 8000000a 8000000e 0 0 3
0 00000000 00000000 00000000 0 03 00000099 00000000
00000013 00000000 00000000 00 00000000 8000000e 0 0 00000000 00000000 0 0
0 0000 00310283 02 10000000 00 00000000 8000000e 80000012 1 0 0
0 10000003 55555555 000000a5 1 05 ffffffa5 00000000
00310283 10000000 00000000 05 ffffffa5 80000012 1 0 000000a5 00000000 0 0
0 0000 00211303 02 10000000 00 00000000 80000012 80000016 1 0 1
0 10000002 00000000 0000beef 1 06 ffffbeef 00000000
00211303 10000000 00000000 06 ffffbeef 80000016 3 0 0000beef 00000000 0 0
0 0000 00012383 02 10000000 00 00000000 80000016 8000001a 1 0 2
0 10000000 00000000 cafef00d 1 07 cafef00d 00000000
00012383 10000000 00000000 07 cafef00d 8000001a f 0 cafef00d 00000000 0 0
0 0000 00312323 02 10000000 03 11223344 8000001a 8000001e 1 1 2
0 10000006 11223344 9abcdef0 0 00 00000000 00000000
00312323 10000000 11223344 00 00000000 8000001e 0 f 00000000 33441122 0 0
0 0000 004100a3 02 10000000 04 000000ab 8000001e 80000022 1 1 0
0 10000001 000000ab 00000000 0 00 00000000 00000000
004100a3 10000000 000000ab 00 00000000 80000022 0 1 00000000 ab000000 0 0
0 0000 005111a3 02 10000000 05 0000cdef 80000022 80000026 1 1 1
0 10000003 0000cdef 00000000 0 00 00000000 00000000
005111a3 10000000 0000cdef 00 00000000 80000026 0 3 00000000 00cdef00 0 0
0 0000 00000000 00 00000000 00 00000000 80000026 8000002a 1 0 2
1 10000000 00000000 12345678 0 00 00000000 80000101
00000000 00000000 00000000 00 00000000 80000100 0 0 00000000 00000000 1 0
0 0000 004f8f93 1f 00000003 00 00000000 80000100 80000104 0 0 3
0 00000000 00000000 00000000 1 1f 00000007 00000000
004f8f93 00000003 00000000 1f 00000007 80000104 0 0 00000000 00000000 0 0
0 0000 0000006f 00 00000000 00 00000000 80000200 80000205 0 0 3
0 00000000 00000000 00000000 0 00 00000000 00000000
0000006f 00000000 00000000 00 00000000 80000204 0 0 00000000 00000000 0 1
0 0000 00418133 03 00000030 04 00000040 80000204 80000208 0 0 3
0 00000000 00000000 00000000 1 02 00000070 00000000
00418133 00000030 00000040 02 00000070 80000208 0 0 00000000 00000000 0 0

// ==== project.f ====
design/rvfi_pkg.sv
design/rvfi_decode_capture.sv
design/rvfi_execute_stage.sv
design/rvfi_writeback_stage.sv
design/rvfi_intr_detect.sv
design/rvfi_tracer.sv
verification/tb_clock_gen.sv
verification/tb_rvfi_tracer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the RVFI tracer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal \
  --top-module tb_rvfi_tracer \
  -Mdir "$OBJ" \
  -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/Vtb_rvfi_tracer" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
